/* design/pmp_defines.svh */
`ifndef PMP_DEFINES_SVH
`define PMP_DEFINES_SVH

// Number of protection regions
`define PMP_NUM_REGIONS 4

// Granularity G, regions are at least 2^(G+2) bytes
// NA4 is not selectable for G >= 1
`define PMP_GRAN 2

// Wishbone word map
// Word 0 holds the four packed config bytes, region 0 in the low byte
`define PMP_CFG_WORD 0

// First address register, one word per region from here on
`define PMP_ADDR_WORD 4

// Wishbone word address width
`define PMP_WB_AW 3

`endif

/* design/pmp_pkg.sv */
package pmp_pkg;

`include "pmp_defines.svh"

  typedef logic [31:0] wb_data_t;
  typedef logic [`PMP_WB_AW-1:0] wb_adr_t;
  typedef logic [$clog2(`PMP_NUM_REGIONS)-1:0] pmp_idx_t;

  // Word address register, byte-address bits 31:2 and up
  typedef logic [31:0] pmp_addr_t;

  // Byte address of an access
  typedef logic [31:0] byte_addr_t;

  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NA4   = 2'b10,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  typedef enum logic [1:0] {
    ACC_EXEC  = 2'b00,
    ACC_READ  = 2'b01,
    ACC_WRITE = 2'b10
  } pmp_acc_e;

  // Same bit layout as a RISC-V pmpcfg byte
  typedef struct packed {
    logic      lock;
    logic [1:0] zero;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // Software view of every region
  typedef struct packed {
    pmp_cfg_t  [`PMP_NUM_REGIONS-1:0] cfg;
    pmp_addr_t [`PMP_NUM_REGIONS-1:0] addr;
  } pmp_state_t;

  typedef struct packed {
    logic     valid;
    logic     is_cfg;
    pmp_idx_t idx;
    wb_data_t data;
  } pmp_csr_wr_t;

  typedef struct packed {
    logic       valid;
    byte_addr_t addr;
    pmp_acc_e   acc;
    priv_lvl_e  priv;
  } pmp_req_t;

  typedef struct packed {
    logic     valid;
    logic     allowed;
    logic     matched;
    pmp_idx_t idx;
  } pmp_rsp_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_adr_t  adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

endpackage

/* design/pmp_csr_wb.sv */
`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_csr_wb
  import pmp_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  wb_req_t     wb_req_i,
  output wb_rsp_t     wb_rsp_o,
  input  pmp_state_t  state_i,
  output pmp_csr_wr_t csr_wr_o
);

  logic     accept;
  logic     is_cfg;
  logic     is_addr;
  wb_adr_t  addr_off;
  pmp_idx_t addr_idx;
  wb_data_t rdata_d;

  logic     ack_q;
  wb_data_t rdata_q;
  logic     wr_valid_q;
  logic     wr_is_cfg_q;
  pmp_idx_t wr_idx_q;
  wb_data_t wr_data_q;

  // During the ack cycle the master still shows the finished transfer
  assign accept = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  // Word decode
  assign is_cfg   = (wb_req_i.adr == wb_adr_t'(`PMP_CFG_WORD));
  assign addr_off = wb_req_i.adr - wb_adr_t'(`PMP_ADDR_WORD);
  assign is_addr  = (wb_req_i.adr >= wb_adr_t'(`PMP_ADDR_WORD)) &&
                    (addr_off < wb_adr_t'(`PMP_NUM_REGIONS));
  assign addr_idx = pmp_idx_t'(addr_off);

  // Read mux, unmapped words give zero
  always_comb begin
    rdata_d = '0;
    if (is_cfg) begin
      rdata_d = state_i.cfg;
    end else if (is_addr) begin
      rdata_d = state_i.addr[addr_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      wr_valid_q <= 1'b0;
    end else begin
      ack_q      <= accept;
      // Unmapped writes still get their ack
      wr_valid_q <= accept && wb_req_i.we && (is_cfg || is_addr);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q     <= rdata_d;
      wr_is_cfg_q <= is_cfg;
      wr_idx_q    <= addr_idx;
      wr_data_q   <= wb_req_i.dat;
    end
  end

  assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};

  // Write pulse lines up with ack
  assign csr_wr_o = '{
    valid:  wr_valid_q,
    is_cfg: wr_is_cfg_q,
    idx:    wr_idx_q,
    data:   wr_data_q
  };

  // Every transfer gets exactly one ack cycle
  a_ack_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ack_q |=> !ack_q
  );

endmodule

/* design/pmp_cfg_regs.sv */
`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_cfg_regs
  import pmp_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  pmp_csr_wr_t csr_wr_i,
  output pmp_state_t  state_o
);

  // Low address bits forced in the read view
  localparam pmp_addr_t NAPOT_ONES =
    (`PMP_GRAN >= 2) ? pmp_addr_t'((1 << (`PMP_GRAN - 1)) - 1) : '0;
  localparam pmp_addr_t TOR_KEEP = ~pmp_addr_t'((1 << `PMP_GRAN) - 1);

  pmp_cfg_t  [`PMP_NUM_REGIONS-1:0] cfg_q;
  pmp_cfg_t  [`PMP_NUM_REGIONS-1:0] cfg_d;
  pmp_addr_t [`PMP_NUM_REGIONS-1:0] addr_q;
  pmp_addr_t [`PMP_NUM_REGIONS-1:0] addr_d;
  pmp_addr_t [`PMP_NUM_REGIONS-1:0] addr_view;

  logic [`PMP_NUM_REGIONS-1:0] lock_vec;
  logic [`PMP_NUM_REGIONS-1:0] tor_lock;
  logic [`PMP_NUM_REGIONS-1:0] addr_lock;

  // WARL rules for one config byte, later rules override earlier ones
  function automatic pmp_cfg_t legalize_cfg(pmp_cfg_t old_cfg, pmp_cfg_t new_cfg);
    pmp_cfg_t res;
    res = new_cfg;
    // R=0 W=1 is reserved
    if (!new_cfg.read && new_cfg.write) begin
      res.read  = old_cfg.read;
      res.write = old_cfg.write;
      res.exec  = old_cfg.exec;
    end
    if ((`PMP_GRAN >= 1) && (new_cfg.mode == PMP_NA4)) begin
      res.mode = old_cfg.mode;
    end
    if (old_cfg.lock) begin
      res = old_cfg;
    end
    res.zero = '0;
    return res;
  endfunction

  // Lock flags per region
  always_comb begin
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      lock_vec[i] = cfg_q[i].lock;
      tor_lock[i] = cfg_q[i].lock && (cfg_q[i].mode == PMP_TOR);
    end
  end

  // A locked TOR entry also freezes the address below it
  assign addr_lock = lock_vec | {1'b0, tor_lock[`PMP_NUM_REGIONS-1:1]};

  always_comb begin
    cfg_d  = cfg_q;
    addr_d = addr_q;
    if (csr_wr_i.valid) begin
      if (csr_wr_i.is_cfg) begin
        for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
          cfg_d[i] = legalize_cfg(cfg_q[i], pmp_cfg_t'(csr_wr_i.data[8*i +: 8]));
        end
      end else if (!addr_lock[csr_wr_i.idx]) begin
        addr_d[csr_wr_i.idx] = csr_wr_i.data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else begin
      cfg_q  <= cfg_d;
      addr_q <= addr_d;
    end
  end

  // Granularity view, stored bits stay as written
  always_comb begin
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      case (cfg_q[i].mode)
        PMP_NAPOT: addr_view[i] = addr_q[i] | NAPOT_ONES;
        PMP_NA4:   addr_view[i] = addr_q[i];
        default:   addr_view[i] = addr_q[i] & TOR_KEEP;
      endcase
    end
  end

  assign state_o = '{cfg: cfg_q, addr: addr_view};

  // Once locked, an entry holds until reset
  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : gen_lock_check
    a_locked_stable: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      cfg_q[i].lock |=> $stable(cfg_q[i]) && $stable(addr_q[i])
    );
  end

endmodule

/* design/pmp_access_check.sv */
`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_access_check
  import pmp_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  pmp_state_t state_i,
  input  pmp_req_t   req_i,
  output pmp_rsp_t   rsp_o
);

  pmp_addr_t word_addr;
  logic [`PMP_NUM_REGIONS-1:0] match;
  logic      hit;
  pmp_idx_t  hit_idx;
  pmp_cfg_t  hit_cfg;
  logic      perm;
  logic      allowed;

  logic      rsp_valid_q;
  logic      allowed_q;
  logic      hit_q;
  pmp_idx_t  hit_idx_q;

  // Word address in the same units as the address registers
  assign word_addr = {2'b00, req_i.addr[31:2]};

  // Region match
  always_comb begin : p_match
    pmp_addr_t prev_addr;
    pmp_addr_t napot_mask;
    prev_addr  = '0;
    napot_mask = '0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      case (state_i.cfg[i].mode)
        PMP_TOR: begin
          match[i] = (word_addr >= prev_addr) && (word_addr < state_i.addr[i]);
        end
        PMP_NAPOT: begin
          // Trailing ones plus the next zero select the size
          napot_mask = ~(state_i.addr[i] ^ (state_i.addr[i] + 32'd1));
          match[i]   = ((word_addr ^ state_i.addr[i]) & napot_mask) == '0;
        end
        // NA4 can't be stored at this granularity
        default: match[i] = 1'b0;
      endcase
      prev_addr = state_i.addr[i];
    end
  end

  // Lowest region wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = `PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        hit_idx = pmp_idx_t'(i);
      end
    end
  end

  assign hit_cfg = state_i.cfg[hit_idx];

  always_comb begin
    case (req_i.acc)
      ACC_EXEC:  perm = hit_cfg.exec;
      ACC_READ:  perm = hit_cfg.read;
      ACC_WRITE: perm = hit_cfg.write;
      default:   perm = 1'b0;
    endcase
  end

  always_comb begin
    if (!hit) begin
      allowed = (req_i.priv == PRIV_M);
    end else if ((req_i.priv == PRIV_M) && !hit_cfg.lock) begin
      allowed = 1'b1;
    end else begin
      allowed = perm;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      allowed_q <= allowed;
      hit_q     <= hit;
      hit_idx_q <= hit_idx;
    end
  end

  assign rsp_o = '{valid: rsp_valid_q, allowed: allowed_q, matched: hit_q, idx: hit_idx_q};

  // One response per request, one cycle later
  a_rsp_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rsp_o.valid == $past(req_i.valid)
  );

endmodule

/* design/pmp_top.sv */
`timescale 1ns/1ps

module pmp_top
  import pmp_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  // Wishbone CSR port
  input  wb_req_t  wb_req_i,
  output wb_rsp_t  wb_rsp_o,

  // Access requests
  input  pmp_req_t req_i,
  output pmp_rsp_t rsp_o
);

  pmp_state_t  state;
  pmp_csr_wr_t csr_wr;

  // Bus side
  pmp_csr_wb i_pmp_csr_wb (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .state_i  (state),
    .csr_wr_o (csr_wr)
  );

  // Config and address storage
  pmp_cfg_regs i_pmp_cfg_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .csr_wr_i (csr_wr),
    .state_o  (state)
  );

  // Permission decision
  pmp_access_check i_pmp_access_check (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .state_i (state),
    .req_i   (req_i),
    .rsp_o   (rsp_o)
  );

endmodule

/* tb/pmp_tb.sv */
`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_tb
  import pmp_pkg::*;
;

  localparam time CLK_PERIOD = 8ns;
  localparam int N_CFG_WR = 200;
  localparam int N_ROUNDS = 10;
  localparam int REQ_PER_ROUND = 50;
  // Bus operations plus requests summed over all five tests
  localparam int N_OPS = 10 + 2 * N_CFG_WR + 116 + 20 + N_ROUNDS * (5 + REQ_PER_ROUND);
  localparam int N_RESETS = 1 + N_CFG_WR / 50 + 2 + N_ROUNDS;
  localparam time TIMEOUT = (N_OPS * 4 + N_RESETS * 12 + 200) * CLK_PERIOD;
  localparam int ADDR_END = `PMP_ADDR_WORD + `PMP_NUM_REGIONS;
  // OFF, TOR, NAPOT, then back through OFF to NAPOT
  localparam logic [1:0] MODE_SEQ [5] = '{2'b00, 2'b01, 2'b11, 2'b00, 2'b11};

  logic     clk_i;
  logic     rst_ni;
  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;
  pmp_req_t req;
  pmp_rsp_t rsp;

  // Mirror of the raw register contents
  logic [7:0]  cfg_m  [`PMP_NUM_REGIONS];
  logic [31:0] addr_m [`PMP_NUM_REGIONS];

  bit          op_is_read_q [$];
  logic [31:0] op_exp_q [$];
  string       op_name_q [$];
  logic [3:0]  rsp_exp_q [$];
  string       rsp_name_q [$];
  logic        req_valid_q;
  int          n_checks;
  int          n_errors;

  pmp_top i_pmp_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp),
    .req_i    (req),
    .rsp_o    (rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Request valid as the DUT sees it at each rising edge
  always @(posedge clk_i) begin
    req_valid_q <= req.valid;
  end

  // Config byte has L at 7, zero bits 6:5, mode 4:3 and X W R at 2:0
  function automatic logic [7:0] ref_legalize(logic [7:0] old_cfg, logic [7:0] new_cfg);
    logic [7:0] res;
    res = new_cfg;
    if (new_cfg[1:0] == 2'b10) begin
      res[2:0] = old_cfg[2:0];
    end
    if ((`PMP_GRAN >= 1) && (new_cfg[4:3] == 2'b10)) begin
      res[4:3] = old_cfg[4:3];
    end
    if (old_cfg[7]) begin
      res = old_cfg;
    end
    res[6:5] = 2'b00;
    return res;
  endfunction

  function automatic logic [31:0] ref_view(int i);
    logic [31:0] v;
    v = addr_m[i];
    for (int b = 0; b < `PMP_GRAN; b++) begin
      if (cfg_m[i][4:3] == 2'b11) begin
        if (b < `PMP_GRAN - 1) v[b] = 1'b1;
      end else if (cfg_m[i][4:3] != 2'b10) begin
        v[b] = 1'b0;
      end
    end
    return v;
  endfunction

  function automatic logic ref_addr_locked(int i);
    logic next_tor_lock;
    next_tor_lock = 1'b0;
    if (i < `PMP_NUM_REGIONS - 1) begin
      next_tor_lock = cfg_m[i+1][7] && (cfg_m[i+1][4:3] == 2'b01);
    end
    return cfg_m[i][7] || next_tor_lock;
  endfunction

  function automatic logic [31:0] ref_read(int word);
    logic [31:0] r;
    r = '0;
    if (word == `PMP_CFG_WORD) begin
      for (int i = 0; i < `PMP_NUM_REGIONS; i++) r[8*i +: 8] = cfg_m[i];
    end else if ((word >= `PMP_ADDR_WORD) && (word < ADDR_END)) begin
      r = ref_view(word - `PMP_ADDR_WORD);
    end
    return r;
  endfunction

  function automatic logic ref_region_hit(int i, logic [31:0] w);
    logic [31:0] top;
    logic [31:0] base;
    int ones;
    top = ref_view(i);
    base = '0;
    ones = 0;
    case (cfg_m[i][4:3])
      2'b01: begin
        if (i > 0) base = ref_view(i - 1);
        return (w >= base) && (w < top);
      end
      2'b11: begin
        while ((ones < 32) && top[ones]) ones++;
        // Almost all ones covers the whole space
        if (ones >= 31) return 1'b1;
        return (w >> (ones + 1)) == (top >> (ones + 1));
      end
      default: return 1'b0;
    endcase
  endfunction

  // Result packs allowed, matched and the two index bits
  function automatic logic [3:0] ref_decide(logic [31:0] baddr, pmp_acc_e acc,
                                            priv_lvl_e priv);
    logic [31:0] w;
    logic found;
    int idx;
    logic perm;
    logic allowed;
    w = baddr >> 2;
    found = 1'b0;
    idx = 0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      if (!found && ref_region_hit(i, w)) begin
        found = 1'b1;
        idx = i;
      end
    end
    if (!found) begin
      allowed = (priv == PRIV_M);
    end else begin
      case (acc)
        ACC_EXEC:  perm = cfg_m[idx][2];
        ACC_READ:  perm = cfg_m[idx][0];
        ACC_WRITE: perm = cfg_m[idx][1];
        default:   perm = 1'b0;
      endcase
      allowed = ((priv == PRIV_M) && !cfg_m[idx][7]) ? 1'b1 : perm;
    end
    return {allowed, found, idx[1:0]};
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic do_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    wb_req = '0;
    req    = '0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      cfg_m[i]  = '0;
      addr_m[i] = '0;
    end
  endtask

  // One Wishbone classic transfer held until ack
  task automatic bus_access(logic we, int word, logic [31:0] dat, string name);
    int wait_cycles;
    @(negedge clk_i);
    if (we) begin
      if (word == `PMP_CFG_WORD) begin
        for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
          cfg_m[i] = ref_legalize(cfg_m[i], dat[8*i +: 8]);
        end
      end else if ((word >= `PMP_ADDR_WORD) && (word < ADDR_END)) begin
        if (!ref_addr_locked(word - `PMP_ADDR_WORD)) addr_m[word - `PMP_ADDR_WORD] = dat;
      end
      op_exp_q.push_back('0);
    end else begin
      op_exp_q.push_back(ref_read(word));
    end
    op_is_read_q.push_back(!we);
    op_name_q.push_back(name);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = wb_adr_t'(word);
    wb_req.dat = dat;
    wait_cycles = 0;
    do begin
      @(negedge clk_i);
      wait_cycles++;
    end while (!wb_rsp.ack);
    // Slave acks in the cycle after it samples the request
    if (wait_cycles != 1) begin
      n_errors++;
      $display("Error: %s acknowledged after %0d cycles instead of one", name, wait_cycles);
    end
    wb_req = '0;
  endtask

  task automatic wb_write(int word, logic [31:0] dat);
    bus_access(1'b1, word, dat, $sformatf("write word %0d", word));
  endtask

  task automatic wb_read(int word, string name);
    bus_access(1'b0, word, '0, name);
  endtask

  task automatic send_req(logic [31:0] baddr, pmp_acc_e acc, priv_lvl_e priv, string name);
    @(negedge clk_i);
    rsp_exp_q.push_back(ref_decide(baddr, acc, priv));
    rsp_name_q.push_back(name);
    req.valid = 1'b1;
    req.addr  = baddr;
    req.acc   = acc;
    req.priv  = priv;
  endtask

  task automatic req_idle();
    @(negedge clk_i);
    req = '0;
  endtask

  task automatic drain();
    while ((op_is_read_q.size() != 0) || (rsp_exp_q.size() != 0)) @(negedge clk_i);
  endtask

  // Random config word with rare locks so entries stay writable
  function automatic logic [31:0] random_cfg_word(int lock_odds);
    logic [31:0] d;
    d = $urandom;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      d[8*i + 7] = ($urandom % lock_odds) == 0;
    end
    return d;
  endfunction

  initial begin : compare
    logic [3:0]  exp_rsp;
    logic [31:0] exp_rd;
    bit          is_rd;
    string       nm;
    forever begin
      @(negedge clk_i);
      if (rst_ni && wb_rsp.ack) begin
        if (op_is_read_q.size() == 0) begin
          n_errors++;
          $display("Error: bus ack seen with no transfer outstanding");
        end else begin
          is_rd  = op_is_read_q.pop_front();
          exp_rd = op_exp_q.pop_front();
          nm     = op_name_q.pop_front();
          if (is_rd) check_value(nm, exp_rd, wb_rsp.dat);
        end
      end
      // A response belongs to the request of the previous cycle
      if (rst_ni) begin
        check_value("response valid", req_valid_q, rsp.valid);
      end
      if (rst_ni && rsp.valid) begin
        if (rsp_exp_q.size() == 0) begin
          n_errors++;
          $display("Error: access response seen with no request outstanding");
        end else begin
          exp_rsp = rsp_exp_q.pop_front();
          nm      = rsp_name_q.pop_front();
          check_value({nm, " allowed"}, exp_rsp[3], rsp.allowed);
          check_value({nm, " matched"}, exp_rsp[2], rsp.matched);
          if (exp_rsp[2]) check_value({nm, " region"}, exp_rsp[1:0], rsp.idx);
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("Timeout: the tests did not finish within %0t", TIMEOUT);
    $display("Some tests failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] data;
    logic [7:0]  cfg_byte;
    rst_ni   = 1'b0;
    wb_req   = '0;
    req      = '0;
    n_checks = 0;
    n_errors = 0;
    void'($urandom(32'h386e_6b80));
    do_reset();

    // Test 1: reset values
    for (int w = 0; w < 8; w++) wb_read(w, $sformatf("reset read word %0d", w));
    send_req(32'h0000_1000, ACC_READ, PRIV_U, "reset U read");
    send_req(32'h0000_1000, ACC_READ, PRIV_M, "reset M read");
    req_idle();
    drain();

    // Test 2: config legalization
    for (int k = 0; k < N_CFG_WR; k++) begin
      if (k % 50 == 0) do_reset();
      wb_write(`PMP_CFG_WORD, random_cfg_word(16));
      wb_read(`PMP_CFG_WORD, $sformatf("cfg write %0d", k));
    end
    drain();

    // Test 3: granularity read view
    do_reset();
    for (int k = 0; k < 4; k++) begin
      for (int r = 0; r < `PMP_NUM_REGIONS; r++) begin
        data = ($urandom & ~32'h3) | k;
        wb_write(`PMP_ADDR_WORD + r, data);
      end
      for (int m = 0; m < 5; m++) begin
        cfg_byte = {3'b000, MODE_SEQ[m], 3'b011};
        wb_write(`PMP_CFG_WORD, {4{cfg_byte}});
        for (int r = 0; r < `PMP_NUM_REGIONS; r++) begin
          wb_read(`PMP_ADDR_WORD + r, $sformatf("view low bits %0d mode %0d region %0d", k, m, r));
        end
      end
    end
    drain();

    // Test 4: region 1 locked in TOR mode
    do_reset();
    for (int r = 0; r < `PMP_NUM_REGIONS; r++) wb_write(`PMP_ADDR_WORD + r, 32'h100 * (r + 1));
    wb_write(`PMP_CFG_WORD, 32'h0B0B_890B);
    wb_write(`PMP_ADDR_WORD, 32'h0000_01F0);
    wb_write(`PMP_ADDR_WORD + 1, 32'h0000_02F0);
    wb_write(`PMP_CFG_WORD, 32'h1B1B_1F1B);
    wb_write(`PMP_ADDR_WORD + 2, 32'h0000_03F0);
    wb_read(`PMP_CFG_WORD, "lock cfg");
    for (int r = 0; r < `PMP_NUM_REGIONS; r++) begin
      wb_read(`PMP_ADDR_WORD + r, $sformatf("lock addr %0d", r));
    end
    send_req(32'h0000_0500, ACC_WRITE, PRIV_M, "locked M write");
    send_req(32'h0000_0500, ACC_READ, PRIV_M, "locked M read");
    send_req(32'h0000_0500, ACC_EXEC, PRIV_U, "locked U exec");
    req_idle();
    drain();

    // Test 5: random requests against random regions
    for (int rnd = 0; rnd < N_ROUNDS; rnd++) begin
      do_reset();
      for (int r = 0; r < `PMP_NUM_REGIONS; r++) begin
        wb_write(`PMP_ADDR_WORD + r, $urandom % 32'h1000);
      end
      wb_write(`PMP_CFG_WORD, random_cfg_word(4));
      for (int n = 0; n < REQ_PER_ROUND; n++) begin
        send_req($urandom % 32'h4400, pmp_acc_e'($urandom % 3),
                 ($urandom % 2) ? PRIV_M : PRIV_U, $sformatf("round %0d req %0d", rnd, n));
        // Occasional idle cycle between requests
        if ($urandom % 8 == 0) req_idle();
      end
      req_idle();
      drain();
    end

    repeat (2) @(negedge clk_i);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+design
design/pmp_pkg.sv
design/pmp_csr_wb.sv
design/pmp_cfg_regs.sv
design/pmp_access_check.sv
design/pmp_top.sv
tb/pmp_tb.sv
